/* compile.f */
+incdir+.
regfile_pkg.sv
operand_prep.sv
status_reg.sv
reg_bank.sv
regfile_top.sv
regfile_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
    -f compile.f --top-module regfile_tb -o regfile_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/regfile_sim); then
  echo "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if grep -q "Done: no errors" <<< "$sim_out"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1

/* regfile_tb.sv */
/*
 * Register file testbench
 * Builds a table of stimulus rows with expected values taken from a
 * behavioral model of the register rules, then applies one row per cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "regfile_params.svh"

module regfile_tb
  import regfile_pkg::*;
();

  // One table row, stimulus first, then expected outputs
  typedef struct packed {
    logic [2:0]  test;
    logic [3:0]  src;                   // Source index
    logic [3:0]  dst;                   // Destination index
    logic        bw;
    logic        dest_wr;
    reg_word_t   dval;
    logic        pc_call;
    logic        sp_wr;
    reg_word_t   sp_val;
    logic        sr_wr;
    logic        sr_clr;
    logic        incr;
    logic [3:0]  alu;
    logic [3:0]  alu_wr;
    reg_word_t   pc;
    reg_word_t   e_src;
    reg_word_t   e_dest;
    logic [3:0]  e_status;
    logic        e_gie;
    logic        e_cpuoff;
    logic        e_oscoff;
    reg_word_t   e_pc_sw;
    logic        e_pc_sw_wr;
  } row_t;

  logic       mclk_r1;
  logic       puc_rst;
  logic [3:0] alu_stat;
  logic [3:0] alu_stat_wr;
  logic       inst_bw;
  reg_sel_t   inst_dest;
  reg_sel_t   inst_src;
  reg_word_t  pc;
  reg_word_t  reg_dest_val;
  logic       reg_dest_wr;
  logic       reg_pc_call;
  reg_word_t  reg_sp_val;
  logic       reg_sp_wr;
  logic       reg_sr_wr;
  logic       reg_sr_clr;
  logic       reg_incr;
  reg_word_t  reg_src;
  reg_word_t  reg_dest;
  logic [3:0] status;
  logic       gie;
  logic       cpuoff;
  logic       oscoff;
  reg_word_t  pc_sw;
  logic       pc_sw_wr;

  reg_word_t   m_regs [`REG_N];         // Model registers, R0 and R2 unused
  sr_word_t    m_sr;                    // Model R2
  row_t        cur;                     // Row being built
  row_t        rows [$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  logic        rst_ok;
  string       test_names [6] = '{"reset values", "write and read", "auto-increment",
                                  "stack pointer", "status flags", "interrupt clear"};

  regfile_top dut_i (.*);

  always #4 mclk_r1 = ~mclk_r1;         // 8 ns period

  function automatic reg_word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];            // Upper bits are the better ones
  endfunction

  function automatic reg_word_t read_model(input logic [3:0] idx, input reg_word_t pcv);
    if (idx == 4'd0) begin
      return pcv;                       // R0 is the external PC
    end
    if (idx == 4'd2) begin
      return m_sr.word;
    end
    return m_regs[idx];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////////////////////////////////////////

  task automatic new_row(input logic [2:0] test);
    cur      = '0;
    cur.test = test;
  endtask

  // Fill in expected outputs, advance the model, store the row
  task automatic add_row();
    logic [3:0] s_eff;
    reg_word_t  dv;
    reg_word_t  incr;
    sr_word_t   nxt;
    logic       r2_wr;
    s_eff  = cur.sr_clr ? 4'd2 : cur.src;   // Interrupt entry reads R2
    dv     = cur.bw ? {8'h00, cur.dval[7:0]} : cur.dval;
    r2_wr  = (cur.dest_wr && cur.dst == 4'd2) || cur.sr_wr;
    cur.e_src      = read_model(s_eff, cur.pc);
    cur.e_dest     = read_model(cur.dst, cur.pc);
    incr           = cur.e_src + ((cur.bw && s_eff != 4'd1) ? 16'd1 : 16'd2);
    cur.e_pc_sw    = dv;
    cur.e_pc_sw_wr = (cur.dest_wr && cur.dst == 4'd0) || cur.pc_call;
    cur.e_status   = {m_sr.f.v, m_sr.f.n, m_sr.f.z, m_sr.f.c};
    cur.e_gie      = m_sr.f.gie;
    cur.e_oscoff   = m_sr.f.oscoff;
    cur.e_cpuoff   = m_sr.f.cpuoff | (r2_wr & dv[4]);  // Early stop
    nxt = m_sr;
    if (r2_wr) begin
      nxt.word = dv;
    end
    if (cur.alu_wr[0]) nxt.f.c = cur.alu[0];
    if (cur.alu_wr[1]) nxt.f.z = cur.alu[1];
    if (cur.alu_wr[2]) nxt.f.n = cur.alu[2];
    if (cur.alu_wr[3]) nxt.f.v = cur.alu[3];
    m_sr.word = cur.sr_clr ? 16'h0000 : (nxt.word & `SR_MASK);
    if (cur.dest_wr && cur.dst == 4'd1) begin
      m_regs[1] = dv & 16'hfffe;
    end else if (cur.sp_wr) begin
      m_regs[1] = cur.sp_val & 16'hfffe;
    end else if (cur.incr && s_eff == 4'd1) begin
      m_regs[1] = incr & 16'hfffe;
    end
    if (cur.dest_wr && cur.dst == 4'd3) begin
      m_regs[3] = dv;                   // Never increments
    end
    for (int i = 4; i < `REG_N; i++) begin
      if (cur.dest_wr && cur.dst == 4'(i)) begin
        m_regs[i] = dv;
      end else if (cur.incr && s_eff == 4'(i)) begin
        m_regs[i] = incr;
      end
    end
    rows.push_back(cur);
  endtask

  task automatic build_table();
    logic [17:0] r1_mix;                // {dest_wr, sp_wr, incr} per step
    r1_mix = {3'b000, 3'b001, 3'b011, 3'b111, 3'b010, 3'b100};
    for (int i = 0; i < `REG_N; i++) begin
      new_row(3'd1);
      cur.src = 4'(i);
      cur.dst = 4'(15 - i);
      add_row();
    end
    for (int i = 3; i < `REG_N; i++) begin  // Writes, R0 read on the source port
      new_row(3'd2);
      cur.dst     = 4'(i);
      cur.dest_wr = 1'b1;
      cur.bw      = (i % 4 == 0);
      cur.dval    = next_rand();
      cur.pc      = next_rand();
      add_row();
    end
    for (int i = 0; i < `REG_N + 2; i++) begin
      new_row(3'd2);
      cur.src     = 4'(i % `REG_N);
      cur.dst     = (i < `REG_N) ? 4'(i) : 4'd0;
      cur.dest_wr = (i == `REG_N);      // R0 byte write
      cur.bw      = (i == `REG_N);
      cur.pc_call = (i == `REG_N + 1);
      cur.dval    = next_rand();
      cur.pc      = next_rand();
      add_row();
    end
    for (int p = 0; p < 3; p++) begin   // Two increment passes, then reads
      for (int i = 0; i < `REG_N; i++) begin
        new_row(3'd3);
        cur.src  = 4'(i);
        cur.dst  = 4'(i);
        cur.incr = (p < 2);
        cur.bw   = i[0] ^ p[0];
        add_row();
      end
    end
    for (int k = 0; k < 6; k++) begin
      new_row(3'd4);
      cur.src     = 4'd1;
      cur.dst     = 4'd1;
      cur.dest_wr = r1_mix[3*k+2];
      cur.sp_wr   = r1_mix[3*k+1];
      cur.incr    = r1_mix[3*k];
      cur.bw      = k[0];
      cur.dval    = next_rand() | 16'h0001;  // Odd on purpose
      cur.sp_val  = next_rand() | 16'h0001;
      add_row();
    end
    for (int k = 0; k < 10; k++) begin
      new_row(3'd5);
      cur.src = 4'd2;
      cur.dst = 4'd2;
      if (k < 6 || k == 8) begin
        cur.alu    = 4'(next_rand());
        cur.alu_wr = 4'(next_rand());
      end
      cur.dest_wr = (k == 6 || k == 8);
      cur.sr_wr   = (k == 7);
      cur.dval    = (k == 7) ? 16'hffef : (next_rand() | 16'h0010);
      add_row();
    end
    for (int k = 0; k < 4; k++) begin
      new_row(3'd6);
      cur.src     = 4'd5;
      cur.dst     = (k == 2) ? 4'd5 : 4'd2;
      cur.dest_wr = (k == 0);
      cur.dval    = 16'hffff;           // Every implemented bit set
      cur.sr_clr  = (k == 1);
      cur.alu     = 4'hf;
      cur.alu_wr  = (k == 1) ? 4'hf : 4'h0;  // Clear still wins
      add_row();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    alu_stat     = 4'h0;
    alu_stat_wr  = 4'h0;
    inst_bw      = 1'b0;
    inst_dest    = '0;
    inst_src     = '0;
    pc           = '0;
    reg_dest_val = '0;
    reg_dest_wr  = 1'b0;
    reg_pc_call  = 1'b0;
    reg_sp_val   = '0;
    reg_sp_wr    = 1'b0;
    reg_sr_wr    = 1'b0;
    reg_sr_clr   = 1'b0;
    reg_incr     = 1'b0;
  endtask

  task automatic drive_row(input row_t r);
    inst_src     = reg_sel_t'(1) << r.src;
    inst_dest    = reg_sel_t'(1) << r.dst;
    inst_bw      = r.bw;
    reg_dest_wr  = r.dest_wr;
    reg_dest_val = r.dval;
    reg_pc_call  = r.pc_call;
    reg_sp_wr    = r.sp_wr;
    reg_sp_val   = r.sp_val;
    reg_sr_wr    = r.sr_wr;
    reg_sr_clr   = r.sr_clr;
    reg_incr     = r.incr;
    alu_stat     = r.alu;
    alu_stat_wr  = r.alu_wr;
    pc           = r.pc;
  endtask

  task automatic check_val(input int k, input string name, input reg_word_t got,
                           input reg_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error row %0d %s: got 0x%h, expected 0x%h", k, name, got, exp);
    end
  endtask

  task automatic check_row(input int k, input row_t r);
    check_val(k, "reg_src", reg_src, r.e_src);
    check_val(k, "reg_dest", reg_dest, r.e_dest);
    check_val(k, "status", 16'(status), 16'(r.e_status));
    check_val(k, "gie", 16'(gie), 16'(r.e_gie));
    check_val(k, "cpuoff", 16'(cpuoff), 16'(r.e_cpuoff));
    check_val(k, "oscoff", 16'(oscoff), 16'(r.e_oscoff));
    check_val(k, "pc_sw", pc_sw, r.e_pc_sw);
    check_val(k, "pc_sw_wr", 16'(pc_sw_wr), 16'(r.e_pc_sw_wr));
  endtask

  // Outputs must settle to idle within a bounded number of cycles
  task automatic wait_reset_quiet(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < 16 && !ok; n++) begin
      @(negedge mclk_r1);
      ok = !puc_rst && status == 4'h0 && !gie && !cpuoff && !oscoff && !pc_sw_wr;
    end
  endtask

  task automatic apply_table();
    int base;                           // Error count at test start
    base = 0;
    for (int k = 0; k < rows.size(); k++) begin
      @(negedge mclk_r1);
      drive_row(rows[k]);
      #2;                               // Mid low phase, before the rising edge
      check_row(k, rows[k]);
      if (k == rows.size() - 1 || rows[k+1].test != rows[k].test) begin
        $display("Test %0d %s: %0d errors", rows[k].test,
                 test_names[int'(rows[k].test) - 1], errors - base);
        base = errors;
      end
    end
    @(negedge mclk_r1);
    idle_inputs();
  endtask

  initial begin
    mclk_r1   = 1'b0;
    puc_rst   = 1'b1;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'h62cd_db37;
    m_sr      = '0;
    for (int i = 0; i < `REG_N; i++) begin
      m_regs[i] = '0;
    end
    idle_inputs();
    build_table();
    repeat (2) @(posedge mclk_r1);
    @(negedge mclk_r1);
    puc_rst = 1'b0;
    wait_reset_quiet(rst_ok);
    if (!rst_ok) begin
      $display("Outputs did not go idle within 16 cycles after reset release");
      $display("Done: errors found");
    end else begin
      apply_table();
      $display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* regfile_top.sv */
/*
 * MSP430 CPU register file
 * Operand preparation, status register and register storage
 * around a combinational pair of read ports
 */

`timescale 1ns/1ps
`default_nettype none

module regfile_top
  import regfile_pkg::*;
(
  input  wire            mclk_r1,       // Core clock
  input  wire            puc_rst,       // Async reset, active high
  input  wire [3:0]      alu_stat,      // ALU flags {V,N,Z,C}
  input  wire [3:0]      alu_stat_wr,   // ALU flag writes {V,N,Z,C}
  input  wire            inst_bw,       // Byte width instruction
  input  wire reg_sel_t  inst_dest,     // Destination select
  input  wire reg_sel_t  inst_src,      // Source select
  input  wire reg_word_t pc,            // Program counter
  input  wire reg_word_t reg_dest_val,  // Destination write value
  input  wire            reg_dest_wr,   // Destination write strobe
  input  wire            reg_pc_call,   // PC update for CALL
  input  wire reg_word_t reg_sp_val,    // Stack pointer next value
  input  wire            reg_sp_wr,     // Stack pointer write
  input  wire            reg_sr_wr,     // R2 restore for RETI
  input  wire            reg_sr_clr,    // R2 clear for interrupts
  input  wire            reg_incr,      // Increment source register
  output reg_word_t      reg_src,       // Source read
  output reg_word_t      reg_dest,      // Destination read
  output logic [3:0]     status,        // {V,N,Z,C}
  output logic           gie,           // Global interrupt enable
  output logic           cpuoff,        // CPU off
  output logic           oscoff,        // LFXT1 off
  output reg_word_t      pc_sw,         // PC software value
  output logic           pc_sw_wr       // PC software write
);

  wire reg_sel_t  src_sel;              // Source select after override
  wire reg_word_t dest_val_in;          // Byte masked write value
  wire reg_word_t incr_val;             // Source plus step
  wire reg_word_t r2;                   // Status register word

  //////////////////////////////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////////////////////////////

  operand_prep prep_i (
    .inst_src     (inst_src),
    .inst_dest    (inst_dest),
    .inst_bw      (inst_bw),
    .reg_sr_clr   (reg_sr_clr),
    .reg_dest_wr  (reg_dest_wr),
    .reg_pc_call  (reg_pc_call),
    .reg_dest_val (reg_dest_val),
    .reg_src      (reg_src),            // Feeds the increment adder
    .src_sel      (src_sel),
    .dest_val_in  (dest_val_in),
    .incr_val     (incr_val),
    .pc_sw        (pc_sw),
    .pc_sw_wr     (pc_sw_wr)
  );

  // R2 and mode decode
  status_reg sr_i (
    .mclk_r1     (mclk_r1),
    .puc_rst     (puc_rst),
    .inst_dest   (inst_dest),
    .reg_dest_wr (reg_dest_wr),
    .reg_sr_wr   (reg_sr_wr),
    .reg_sr_clr  (reg_sr_clr),
    .alu_stat    (alu_stat),
    .alu_stat_wr (alu_stat_wr),
    .dest_val_in (dest_val_in),
    .r2          (r2),
    .status      (status),
    .gie         (gie),
    .cpuoff      (cpuoff),
    .oscoff      (oscoff)
  );

  // Storage and read ports
  reg_bank bank_i (
    .mclk_r1     (mclk_r1),
    .puc_rst     (puc_rst),
    .src_sel     (src_sel),
    .inst_dest   (inst_dest),
    .reg_dest_wr (reg_dest_wr),
    .reg_incr    (reg_incr),
    .reg_sp_wr   (reg_sp_wr),
    .reg_sp_val  (reg_sp_val),
    .dest_val_in (dest_val_in),
    .incr_val    (incr_val),
    .pc          (pc),
    .r2          (r2),
    .reg_src     (reg_src),
    .reg_dest    (reg_dest)
  );

endmodule

`default_nettype wire

/* reg_bank.sv */
/*
 * Register storage and read ports
 * Holds R1, R3 and R4 to R15 with write and increment priority
 * R0 and R2 come in from outside for the two AND-OR read muxes
 */

`timescale 1ns/1ps
`default_nettype none

`include "regfile_params.svh"

module reg_bank
  import regfile_pkg::*;
(
  input  wire            mclk_r1,       // Core clock
  input  wire            puc_rst,       // Async reset
  input  wire reg_sel_t  src_sel,       // Effective source select
  input  wire reg_sel_t  inst_dest,     // Destination select
  input  wire            reg_dest_wr,   // Destination write strobe
  input  wire            reg_incr,      // Increment source register
  input  wire            reg_sp_wr,     // Stack pointer write
  input  wire reg_word_t reg_sp_val,    // Stack pointer next value
  input  wire reg_word_t dest_val_in,   // Masked write value
  input  wire reg_word_t incr_val,      // Incremented source
  input  wire reg_word_t pc,            // Program counter as R0
  input  wire reg_word_t r2,            // Status register
  output reg_word_t      reg_src,       // Source read
  output reg_word_t      reg_dest       // Destination read
);

  localparam int cg_idx  = 3;           // Constant generator R3
  localparam int gpr_low = 4;           // First general register

  // Keeps the stack pointer word aligned
  localparam reg_word_t sp_align = ~reg_word_t'(1);

  reg_sel_t  wr_sel;                    // Per register write
  reg_sel_t  inc_sel;                   // Per register increment
  reg_word_t r1;                        // Stack pointer
  reg_word_t r3;                        // Constant generator

  wire reg_word_t reg_view [`REG_N];    // All registers in index order

  assign wr_sel  = inst_dest & {`REG_N{reg_dest_wr}};
  assign inc_sel = src_sel   & {`REG_N{reg_incr}};

  //////////////////////////////////////////////////////////////////////////
  // R1 stack pointer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst) begin
      r1 <= '0;
    end else if (wr_sel[`SP_IDX]) begin
      r1 <= dest_val_in & sp_align;     // Software write first
    end else if (reg_sp_wr) begin
      r1 <= reg_sp_val & sp_align;      // Push and pop
    end else if (inc_sel[`SP_IDX]) begin
      r1 <= incr_val & sp_align;        // Always +2
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // R3 constant generator
  //////////////////////////////////////////////////////////////////////////

  // No increment since @R3+ encodes the constant -1
  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst) begin
      r3 <= '0;
    end else if (wr_sel[cg_idx]) begin
      r3 <= dest_val_in;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // R4 to R15 general registers
  //////////////////////////////////////////////////////////////////////////

  for (genvar i = gpr_low; i < `REG_N; i++) begin : g_gpr
    reg_word_t gpr_q;                   // One general register

    always_ff @(posedge mclk_r1 or posedge puc_rst) begin
      if (puc_rst) begin
        gpr_q <= '0;
      end else if (wr_sel[i]) begin
        gpr_q <= dest_val_in;           // Write beats increment
      end else if (inc_sel[i]) begin
        gpr_q <= incr_val;
      end
    end

    assign reg_view[i] = gpr_q;
  end

  // Special registers into the read view
  assign reg_view[0]       = pc;
  assign reg_view[`SP_IDX] = r1;
  assign reg_view[`SR_IDX] = r2;
  assign reg_view[cg_idx]  = r3;

  //////////////////////////////////////////////////////////////////////////
  // Read muxes
  //////////////////////////////////////////////////////////////////////////

  // One-hot selects so a plain AND-OR tree does the job
  always_comb begin
    reg_src  = '0;
    reg_dest = '0;
    for (int i = 0; i < `REG_N; i++) begin
      reg_src  = reg_src  | (reg_view[i] & {`REG_W{src_sel[i]}});
      reg_dest = reg_dest | (reg_view[i] & {`REG_W{inst_dest[i]}});
    end
  end

endmodule

`default_nettype wire

/* status_reg.sv */
/*
 * Status register R2
 * Per-flag ALU updates, direct writes under the implemented-bit
 * mask, clear on interrupt entry and decoded mode outputs
 */

`timescale 1ns/1ps
`default_nettype none

`include "regfile_params.svh"

module status_reg
  import regfile_pkg::*;
(
  input  wire            mclk_r1,       // Core clock
  input  wire            puc_rst,       // Async reset
  input  wire reg_sel_t  inst_dest,     // Destination select
  input  wire            reg_dest_wr,   // Destination write strobe
  input  wire            reg_sr_wr,     // R2 restore for RETI
  input  wire            reg_sr_clr,    // R2 clear for interrupts
  input  wire [3:0]      alu_stat,      // ALU flags {V,N,Z,C}
  input  wire [3:0]      alu_stat_wr,   // ALU flag writes {V,N,Z,C}
  input  wire reg_word_t dest_val_in,   // Masked write value
  output reg_word_t      r2,            // R2 for the read ports
  output logic [3:0]     status,        // {V,N,Z,C}
  output logic           gie,           // Global interrupt enable
  output logic           cpuoff,        // CPU off request
  output logic           oscoff         // LFXT1 off request
);

  localparam reg_word_t sr_mask = `SR_MASK;

  sr_word_t sr_q;                       // Stored R2
  sr_word_t sr_nxt;                     // Merged next value
  logic     r2_wr;                      // Direct R2 write

  // Write through destination or RETI restore
  assign r2_wr = (inst_dest[`SR_IDX] & reg_dest_wr) | reg_sr_wr;

  //////////////////////////////////////////////////////////////////////////
  // Flag merge
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    sr_nxt = sr_q;                      // Hold
    if (r2_wr) begin
      sr_nxt.word = dest_val_in;        // V lands from bit 8
    end
    // ALU beats a direct write, flag by flag
    if (alu_stat_wr[0]) begin
      sr_nxt.f.c = alu_stat[0];
    end
    if (alu_stat_wr[1]) begin
      sr_nxt.f.z = alu_stat[1];
    end
    if (alu_stat_wr[2]) begin
      sr_nxt.f.n = alu_stat[2];
    end
    if (alu_stat_wr[3]) begin
      sr_nxt.f.v = alu_stat[3];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst) begin
      sr_q.word <= '0;
    end else if (reg_sr_clr) begin
      sr_q.word <= '0;                  // Interrupt entry
    end else begin
      sr_q.word <= sr_nxt.word & sr_mask;  // Drop unimplemented bits
    end
  end

  // Decoded outputs
  assign r2     = sr_q.word;
  assign status = {sr_q.f.v, sr_q.f.n, sr_q.f.z, sr_q.f.c};
  assign gie    = sr_q.f.gie;
  assign oscoff = sr_q.f.oscoff;

  // CPU stops in the cycle of the write that sets CPUOFF
  assign cpuoff = sr_q.f.cpuoff | (sr_nxt.f.cpuoff & r2_wr);

endmodule

`default_nettype wire

/* operand_prep.sv */
/*
 * Operand preparation
 * Source select override on interrupt entry, byte masking of the
 * destination value, auto-increment adder and PC software write
 */

`timescale 1ns/1ps
`default_nettype none

`include "regfile_params.svh"

module operand_prep
  import regfile_pkg::*;
(
  input  wire reg_sel_t  inst_src,      // Decoded source select
  input  wire reg_sel_t  inst_dest,     // Decoded destination select
  input  wire            inst_bw,       // Byte width instruction
  input  wire            reg_sr_clr,    // R2 clear on interrupt entry
  input  wire            reg_dest_wr,   // Destination write strobe
  input  wire            reg_pc_call,   // PC update for CALL
  input  wire reg_word_t reg_dest_val,  // Raw destination value
  input  wire reg_word_t reg_src,       // Current source read
  output reg_sel_t       src_sel,       // Effective source select
  output reg_word_t      dest_val_in,   // Masked destination value
  output reg_word_t      incr_val,      // Source plus step
  output reg_word_t      pc_sw,         // PC software value
  output logic           pc_sw_wr       // PC software write
);

  // Select of R2 alone
  localparam reg_sel_t sr_only = reg_sel_t'(1) << `SR_IDX;

  reg_word_t incr_step;                 // 1 or 2

  //////////////////////////////////////////////////////////////////////////
  // Source select and write value
  //////////////////////////////////////////////////////////////////////////

  // Interrupt entry reads R2 out through the source port
  assign src_sel = reg_sr_clr ? sr_only : inst_src;

  // Byte ops zero the upper byte
  assign dest_val_in = inst_bw ? {{(`REG_W-8){1'b0}}, reg_dest_val[7:0]}
                               : reg_dest_val;

  //////////////////////////////////////////////////////////////////////////
  // Auto-increment
  //////////////////////////////////////////////////////////////////////////

  // SP keeps word alignment even for byte ops
  assign incr_step = (inst_bw & ~src_sel[`SP_IDX]) ? reg_word_t'(`INCR_BYTE)
                                                  : reg_word_t'(`INCR_WORD);
  assign incr_val  = reg_src + incr_step;  // Shared by all registers

  //////////////////////////////////////////////////////////////////////////
  // R0 software write
  //////////////////////////////////////////////////////////////////////////

  assign pc_sw    = dest_val_in;
  assign pc_sw_wr = (inst_dest[0] & reg_dest_wr) | reg_pc_call;  // Write to R0 or CALL

endmodule

`default_nettype wire

/* regfile_pkg.sv */
/*
 * MSP430 register file types
 * Register word, one-hot register select and the two views
 * of the status register word
 */

`default_nettype none

`include "regfile_params.svh"

package regfile_pkg;

  // One register value
  typedef logic [`REG_W-1:0] reg_word_t;

  // One-hot select, bit n picks Rn
  typedef logic [`REG_N-1:0] reg_sel_t;

  // Status register fields, MSB first
  typedef struct packed {
    logic [6:0] rsvd;           // Unimplemented
    logic       v;              // Overflow
    logic       scg1;           // SMCLK off
    logic       scg0;           // DCO off
    logic       oscoff;         // LFXT1 off
    logic       cpuoff;         // CPU off
    logic       gie;            // Global interrupt enable
    logic       n;              // Negative
    logic       z;              // Zero
    logic       c;              // Carry
  } sr_fields_t;

  // R2 seen as a raw word or as flags
  typedef union packed {
    reg_word_t  word;
    sr_fields_t f;
  } sr_word_t;

endpackage

`default_nettype wire

/* regfile_params.svh */
/*
 * MSP430 register file parameters
 * Register geometry, special register positions, the implemented-bit
 * mask of the status register and the auto-increment steps
 */

`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// Register geometry
`define REG_W 16                // Width of every register and data path
`define REG_N 16                // Number of registers R0 to R15

// Special register positions in the one-hot selects
`define SP_IDX 1                // Stack pointer R1
`define SR_IDX 2                // Status register R2

// Implemented R2 bits for the FPGA build
// C Z N GIE CPUOFF OSCOFF SCG1 V, SCG0 never holds a value
`define SR_MASK 16'h01bf

// Auto-increment steps
`define INCR_BYTE 1             // Byte access
`define INCR_WORD 2             // Word access and stack pointer

`endif
